//--- design/sd_regs_defs.svh
`ifndef SD_REGS_DEFS_SVH
`define SD_REGS_DEFS_SVH

// Register bus geometry
`define SD_WORD_W    32
`define SD_ADDR_W    5
`define SD_RAM_WORDS 8

// Writable bits of OCR and of the interrupt enable
`define SD_OCR_MASK     32'hff00_0000
`define SD_INTR_EN_MASK 32'h18d4_0000

// Latched status bit positions
`define SD_ST_NEW_CMD_SAVED      16
`define SD_ST_NEW_CMD_SAVED_MISS 17
`define SD_ST_NEW_CMD            18
`define SD_ST_NEW_CMD_MISS       19
`define SD_ST_RESET_CMD          21
`define SD_ST_DAT_DONE           25

`endif

//--- design/sd_regs_pkg.sv
`default_nettype none
`include "sd_regs_defs.svh"

package sd_regs_pkg;

   // Word addresses seen by the host
   typedef enum logic [`SD_ADDR_W-1:0] {
      ADDR_RAM0        = 5'd0,
      ADDR_STATUS      = 5'd8,
      ADDR_CSR_READ    = 5'd9,
      ADDR_SAVED_ARG   = 5'd10,
      ADDR_LAST_ARG    = 5'd11,
      ADDR_ERASE_START = 5'd12,
      ADDR_ERASE_END   = 5'd13,
      ADDR_BLOCK_LIMIT = 5'd14,
      ADDR_PRE_ERASE   = 5'd15,
      ADDR_BLOCKS_DONE = 5'd16,
      ADDR_OCR         = 5'd17,
      ADDR_SIZE        = 5'd18,
      ADDR_INTR_EN     = 5'd19,
      ADDR_CONTROL     = 5'd20,
      ADDR_CSR_SET     = 5'd21,
      ADDR_CSR_CLR     = 5'd22
   } reg_addr_e;

   typedef struct packed {
      logic                  we;
      logic                  re;
      logic [`SD_ADDR_W-1:0] addr;
      logic [`SD_WORD_W-1:0] wdata;
   } reg_req_t;

   typedef struct packed {
      logic new_cmd_saved;
      logic new_cmd;
      logic got_reset_cmd;
      logic dat_done;
   } dev_events_t;

   typedef struct packed {
      logic [2:0] dat_error_code;
      logic       pre_erase_used;
      logic       block_limit_used;
      logic       got_cmd8;
      logic       is_inactive;
      logic       last_cmd_valid;
      logic       last_cmd_ignored;
      logic       last_cmd_is_acmd;
      logic [5:0] last_cmd_index;
      logic       saved_cmd_is_acmd;
      logic [5:0] saved_cmd_index;
   } dev_status_t;

   // Word order follows addresses 9 to 16, first field is address 9
   typedef struct packed {
      logic [`SD_WORD_W-1:0] csr_read;
      logic [`SD_WORD_W-1:0] saved_cmd_arg;
      logic [`SD_WORD_W-1:0] last_cmd_arg;
      logic [`SD_WORD_W-1:0] erase_start;
      logic [`SD_WORD_W-1:0] erase_end;
      logic [`SD_WORD_W-1:0] block_limit;
      logic [`SD_WORD_W-1:0] pre_erase_count;
      logic [`SD_WORD_W-1:0] blocks_done;
   } snapshot_t;

   // prog_done sits in bit 0 of the CONTROL word
   typedef struct packed {
      logic start_read;
      logic start_write;
      logic prog_done;
   } ctrl_t;

   typedef enum logic [1:0] {
      RAM_IDLE,
      RAM_WRITE,
      RAM_READ
   } ram_state_e;

endpackage

`default_nettype wire

//--- design/cid_csd_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module cid_csd_ram import sd_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_req_t              req_i,
   input  logic [4:0]            dev_ram_addr_i,
   input  logic                  dev_ram_rd_i,
   output logic [7:0]            dev_ram_data_o,
   output logic                  rd_valid_o,
   output logic [`SD_WORD_W-1:0] rd_data_o
);

   localparam int word_aw = $clog2(`SD_RAM_WORDS);

   logic [7:0]            mem [`SD_RAM_WORDS*4];
   ram_state_e            state;
   logic [1:0]            byte_idx;
   logic [word_aw-1:0]    word_addr;
   logic [`SD_WORD_W-1:0] wr_word;
   logic [`SD_WORD_W-1:0] rd_word;
   logic                  rd_valid_q;
   logic                  ram_hit;

   assign ram_hit = req_i.addr < (ADDR_RAM0 + `SD_RAM_WORDS);

   // Byte-serial sequencer, four cycles per word in either direction
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state      <= RAM_IDLE;
         byte_idx   <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= 1'b0;
         case (state)
            RAM_IDLE: begin
               byte_idx <= '0;
               if (ram_hit && req_i.we)
                  state <= RAM_WRITE;
               else if (ram_hit && req_i.re)
                  state <= RAM_READ;
            end
            RAM_WRITE: begin
               byte_idx <= byte_idx + 2'd1;
               if (byte_idx == 2'd3)
                  state <= RAM_IDLE;
            end
            RAM_READ: begin
               byte_idx <= byte_idx + 2'd1;
               if (byte_idx == 2'd3) begin
                  state      <= RAM_IDLE;
                  rd_valid_q <= 1'b1;
               end
            end
            default: state <= RAM_IDLE;
         endcase
      end
   end

   // Word buffers and the memory itself, MSB byte goes to the lowest address
   always_ff @(posedge clk) begin
      if (state == RAM_IDLE) begin
         word_addr <= req_i.addr[word_aw-1:0];
         wr_word   <= req_i.wdata;
      end else if (state == RAM_WRITE) begin
         mem[{word_addr, byte_idx}] <= wr_word[`SD_WORD_W-1 -: 8];
         wr_word <= wr_word << 8;
      end else if (state == RAM_READ) begin
         rd_word <= {rd_word[`SD_WORD_W-9:0], mem[{word_addr, byte_idx}]};
      end
   end

   // Card-side port runs alongside the host sequencer
   always_ff @(posedge clk) begin
      if (dev_ram_rd_i)
         dev_ram_data_o <= mem[dev_ram_addr_i];
   end

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = rd_valid_q ? rd_word : '0;

   // Host must hold off while a memory access is in flight
   a_no_req_while_busy: assert property (@(posedge clk) disable iff (!resetn)
      (state != RAM_IDLE) |-> !(req_i.we || req_i.re));

endmodule

`default_nettype wire

//--- design/status_latch.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module status_latch import sd_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_req_t              req_i,
   input  dev_events_t           dev_evt_i,
   input  dev_status_t           dev_stat_i,
   input  logic [`SD_WORD_W-1:0] intr_en_i,
   output logic                  status_read_o,
   output logic                  cmd_pending_o,
   output logic                  irq_o,
   output logic                  rd_valid_o,
   output logic [`SD_WORD_W-1:0] rd_data_o
);

   logic [`SD_WORD_W-1:0] evt_set;
   logic [`SD_WORD_W-1:0] latched_q;
   logic [`SD_WORD_W-1:0] current;
   logic [`SD_WORD_W-1:0] status_word;
   logic [`SD_WORD_W-1:0] rd_data_q;
   logic                  rd_valid_q;
   logic                  status_read;

   assign status_read = req_i.re && (req_i.addr == ADDR_STATUS);

   always_comb begin
      evt_set = '0;
      evt_set[`SD_ST_NEW_CMD_SAVED] = dev_evt_i.new_cmd_saved;
      evt_set[`SD_ST_NEW_CMD]       = dev_evt_i.new_cmd;
      evt_set[`SD_ST_RESET_CMD]     = dev_evt_i.got_reset_cmd;
      evt_set[`SD_ST_DAT_DONE]      = dev_evt_i.dat_done;
      // Repeat of a command event before the host looked
      evt_set[`SD_ST_NEW_CMD_SAVED_MISS] =
         dev_evt_i.new_cmd_saved & latched_q[`SD_ST_NEW_CMD_SAVED];
      evt_set[`SD_ST_NEW_CMD_MISS] = dev_evt_i.new_cmd & latched_q[`SD_ST_NEW_CMD];
   end

   assign current = latched_q | evt_set;

   always_ff @(posedge clk) begin
      if (!resetn)
         latched_q <= '0;
      else if (status_read)
         latched_q <= '0;
      else
         latched_q <= current;
   end

   // Level fields fill the gaps between the latched bits
   always_comb begin
      status_word        = current;
      status_word[28:26] = dev_stat_i.dat_error_code;
      status_word[24]    = dev_stat_i.pre_erase_used;
      status_word[23]    = dev_stat_i.block_limit_used;
      status_word[22]    = dev_stat_i.got_cmd8;
      status_word[20]    = dev_stat_i.is_inactive;
      status_word[15]    = dev_stat_i.last_cmd_valid;
      status_word[14]    = dev_stat_i.last_cmd_ignored;
      status_word[13]    = dev_stat_i.last_cmd_is_acmd;
      status_word[12:7]  = dev_stat_i.last_cmd_index;
      status_word[6]     = dev_stat_i.saved_cmd_is_acmd;
      status_word[5:0]   = dev_stat_i.saved_cmd_index;
   end

   always_ff @(posedge clk) begin
      if (!resetn)
         rd_valid_q <= 1'b0;
      else
         rd_valid_q <= status_read;
   end

   always_ff @(posedge clk) begin
      if (status_read)
         rd_data_q <= status_word;
   end

   assign status_read_o = status_read;
   // Control pulses wait until the saved command has been seen
   assign cmd_pending_o = current[`SD_ST_NEW_CMD_SAVED];
   assign irq_o         = |(status_word & intr_en_i);
   assign rd_valid_o    = rd_valid_q;
   assign rd_data_o     = rd_valid_q ? rd_data_q : '0;

endmodule

`default_nettype wire

//--- design/snapshot_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module snapshot_regs import sd_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_req_t              req_i,
   input  logic                  status_read_i,
   input  snapshot_t             dev_snap_i,
   output logic                  rd_valid_o,
   output logic [`SD_WORD_W-1:0] rd_data_o
);

   snapshot_t                        snap_in;
   snapshot_t                        snap_q;
   logic [0:7][`SD_WORD_W-1:0]       snap_words;
   logic [`SD_ADDR_W-1:0]            word_off;
   logic                             snap_hit;
   logic                             rd_valid_q;
   logic [`SD_WORD_W-1:0]            rd_data_q;

   // Pre-erase count is only 23 bits wide
   always_comb begin
      snap_in = dev_snap_i;
      snap_in.pre_erase_count[31:23] = '0;
   end

   always_ff @(posedge clk) begin
      if (!resetn)
         snap_q <= '0;
      else if (status_read_i)
         snap_q <= snap_in;
   end

   assign snap_words = snap_q;
   assign snap_hit   = req_i.re && (req_i.addr >= ADDR_CSR_READ) &&
                       (req_i.addr <= ADDR_BLOCKS_DONE);
   assign word_off   = req_i.addr - ADDR_CSR_READ;

   always_ff @(posedge clk) begin
      if (!resetn)
         rd_valid_q <= 1'b0;
      else
         rd_valid_q <= snap_hit;
   end

   always_ff @(posedge clk) begin
      if (snap_hit)
         rd_data_q <= snap_words[word_off[2:0]];
   end

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = rd_valid_q ? rd_data_q : '0;

endmodule

`default_nettype wire

//--- design/config_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module config_regs import sd_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_req_t              req_i,
   input  logic                  device_reset_i,
   input  logic                  cmd_pending_i,
   output logic [7:0]            ocr_high_o,
   output logic [`SD_WORD_W-1:0] size_o,
   output logic [`SD_WORD_W-1:0] intr_en_o,
   output ctrl_t                 ctrl_o,
   output logic [`SD_WORD_W-1:0] csr_set_o,
   output logic [`SD_WORD_W-1:0] csr_clr_o,
   output logic                  rd_valid_o,
   output logic [`SD_WORD_W-1:0] rd_data_o
);

   logic [`SD_WORD_W-1:0] ocr_q;
   logic [`SD_WORD_W-1:0] size_q;
   logic [`SD_WORD_W-1:0] intr_en_q;
   ctrl_t                 ctrl_q;
   logic                  rd_valid_q;
   logic [`SD_WORD_W-1:0] rd_data_q;
   logic                  cfg_hit;

   // OCR and size follow the card, INTR_EN survives a card reset
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ocr_q     <= '0;
         size_q    <= '0;
         intr_en_q <= '0;
      end else begin
         if (device_reset_i) begin
            ocr_q  <= '0;
            size_q <= '0;
         end else if (req_i.we && req_i.addr == ADDR_OCR) begin
            ocr_q <= req_i.wdata & `SD_OCR_MASK;
         end else if (req_i.we && req_i.addr == ADDR_SIZE) begin
            size_q <= req_i.wdata;
         end
         if (req_i.we && req_i.addr == ADDR_INTR_EN)
            intr_en_q <= req_i.wdata & `SD_INTR_EN_MASK;
      end
   end

   // Write-only registers hold their value for a single cycle
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ctrl_q    <= '0;
         csr_set_o <= '0;
         csr_clr_o <= '0;
      end else begin
         ctrl_q    <= (req_i.we && req_i.addr == ADDR_CONTROL) ? req_i.wdata[2:0] : '0;
         csr_set_o <= (req_i.we && req_i.addr == ADDR_CSR_SET) ? req_i.wdata : '0;
         csr_clr_o <= (req_i.we && req_i.addr == ADDR_CSR_CLR) ? req_i.wdata : '0;
      end
   end

   // Also answers write-only and unmapped addresses, with zero
   assign cfg_hit = req_i.re && (req_i.addr >= ADDR_OCR);

   always_ff @(posedge clk) begin
      if (!resetn)
         rd_valid_q <= 1'b0;
      else
         rd_valid_q <= cfg_hit;
   end

   always_ff @(posedge clk) begin
      if (cfg_hit) begin
         case (req_i.addr)
            ADDR_OCR:     rd_data_q <= ocr_q;
            ADDR_SIZE:    rd_data_q <= size_q;
            ADDR_INTR_EN: rd_data_q <= intr_en_q;
            default:      rd_data_q <= '0;
         endcase
      end
   end

   assign ocr_high_o = ocr_q[31:24];
   assign size_o     = size_q;
   assign intr_en_o  = intr_en_q;
   assign ctrl_o     = cmd_pending_i ? '0 : ctrl_q;
   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = rd_valid_q ? rd_data_q : '0;

   // A pending command still holds one cycle later, so no pulse escapes
   a_ctrl_gated: assert property (@(posedge clk) disable iff (!resetn)
      cmd_pending_i |=> (ctrl_o == '0));

endmodule

`default_nettype wire

//--- design/sd_reg_block.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module sd_reg_block import sd_regs_pkg::*; (
   input  logic                  clk,
   input  logic                  resetn,
   input  reg_req_t              req_i,
   input  dev_events_t           dev_evt_i,
   input  dev_status_t           dev_stat_i,
   input  snapshot_t             dev_snap_i,
   input  logic [4:0]            dev_ram_addr_i,
   input  logic                  dev_ram_rd_i,
   output logic [7:0]            dev_ram_data_o,
   output ctrl_t                 ctrl_o,
   output logic [`SD_WORD_W-1:0] csr_set_o,
   output logic [`SD_WORD_W-1:0] csr_clr_o,
   output logic [7:0]            ocr_high_o,
   output logic [`SD_WORD_W-1:0] size_o,
   output logic                  irq_o,
   output logic                  rd_valid_o,
   output logic [`SD_WORD_W-1:0] rd_data_o
);

   logic                  status_read;
   logic                  cmd_pending;
   logic [`SD_WORD_W-1:0] intr_en;
   logic                  ram_valid;
   logic                  stat_valid;
   logic                  snap_valid;
   logic                  cfg_valid;
   logic [`SD_WORD_W-1:0] ram_data;
   logic [`SD_WORD_W-1:0] stat_data;
   logic [`SD_WORD_W-1:0] snap_data;
   logic [`SD_WORD_W-1:0] cfg_data;

   cid_csd_ram u_ram (
      .*,
      .rd_valid_o (ram_valid),
      .rd_data_o  (ram_data)
   );

   status_latch u_status (
      .*,
      .intr_en_i     (intr_en),
      .status_read_o (status_read),
      .cmd_pending_o (cmd_pending),
      .rd_valid_o    (stat_valid),
      .rd_data_o     (stat_data)
   );

   snapshot_regs u_snap (
      .*,
      .status_read_i (status_read),
      .rd_valid_o    (snap_valid),
      .rd_data_o     (snap_data)
   );

   config_regs u_cfg (
      .*,
      .device_reset_i (dev_evt_i.got_reset_cmd),
      .cmd_pending_i  (cmd_pending),
      .intr_en_o      (intr_en),
      .rd_valid_o     (cfg_valid),
      .rd_data_o      (cfg_data)
   );

   // Idle sources drive zero, so a plain OR merges the answers
   assign rd_valid_o = ram_valid | stat_valid | snap_valid | cfg_valid;
   assign rd_data_o  = ram_data | stat_data | snap_data | cfg_data;

   a_one_answer: assert property (@(posedge clk) disable iff (!resetn)
      $onehot0({ram_valid, stat_valid, snap_valid, cfg_valid}));

   // Register reads take one cycle and nothing may overlap them
   a_read_spacing: assert property (@(posedge clk) disable iff (!resetn)
      (req_i.re && req_i.addr >= `SD_RAM_WORDS) |=> !(req_i.we || req_i.re));

endmodule

`default_nettype wire

//--- test/sd_reg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sd_reg_checker import sd_regs_pkg::*; (
   input  logic        clk,
   input  logic        resetn,
   input  logic        start_i,
   input  logic [3:0]  exp_lat_i,
   input  logic [31:0] exp_rd_i,
   input  ctrl_t       exp_ctrl_i,
   input  logic [31:0] exp_set_i,
   input  logic [31:0] exp_clr_i,
   input  logic        exp_irq_i,
   input  logic        chk_byte_i,
   input  logic [7:0]  exp_byte_i,
   input  logic [7:0]  exp_ocr_i,
   input  logic [31:0] exp_size_i,
   input  logic        rd_valid_i,
   input  logic [31:0] rd_data_i,
   input  ctrl_t       ctrl_i,
   input  logic [31:0] csr_set_i,
   input  logic [31:0] csr_clr_i,
   input  logic        irq_i,
   input  logic [7:0]  dev_byte_i,
   input  logic [7:0]  ocr_high_i,
   input  logic [31:0] size_i,
   output int          done_count_o,
   output int          fail_count_o
);

   int bad_in_test;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
         bad_in_test++;
      end
   endtask

   // Runs from the edge that samples the request
   // Outputs still hold their values from before that edge
   task automatic run_check();
      int   n;
      logic got_answer;
      got_answer  = 1'b0;
      bad_in_test = 0;
      compare("irq_o", 32'(irq_i), 32'(exp_irq_i));
      for (n = 1; n <= 6; n++) begin
         @(posedge clk);
         if (n == 1) begin
            compare("ctrl_o", 32'(ctrl_i), 32'(exp_ctrl_i));
            compare("csr_set_o", csr_set_i, exp_set_i);
            compare("csr_clr_o", csr_clr_i, exp_clr_i);
            compare("ocr_high_o", 32'(ocr_high_i), 32'(exp_ocr_i));
            compare("size_o", size_i, exp_size_i);
            if (chk_byte_i)
               compare("dev_ram_data_o", 32'(dev_byte_i), 32'(exp_byte_i));
         end
         if (rd_valid_i) begin
            if (exp_lat_i == 0 || got_answer) begin
               $display("%0t: unexpected read answer %0d cycles after the request", $time, n);
               bad_in_test++;
            end else begin
               got_answer = 1'b1;
               if (n != exp_lat_i) begin
                  $display("%0t: read answer came after %0d cycles instead of %0d",
                           $time, n, exp_lat_i);
                  bad_in_test++;
               end
               compare("rd_data_o", rd_data_i, exp_rd_i);
            end
         end
      end
      if (exp_lat_i != 0 && !got_answer) begin
         $display("%0t: no read answer within 6 cycles of the request", $time);
         bad_in_test++;
      end
      if (bad_in_test == 0)
         $display("test %0d ok", done_count_o);
      else begin
         $display("test %0d failed with %0d errors", done_count_o, bad_in_test);
         fail_count_o++;
      end
      done_count_o++;
   endtask

   initial begin
      done_count_o = 0;
      fail_count_o = 0;
      forever begin
         @(posedge clk);
         if (resetn && start_i)
            run_check();
      end
   end

endmodule

`default_nettype wire

//--- test/tb_sd_reg_block.sv
`timescale 1ns/1ps
`default_nettype none
`include "sd_regs_defs.svh"

module tb_sd_reg_block import sd_regs_pkg::*; ();

   typedef struct packed {
      reg_req_t    req;
      dev_events_t evt;
      dev_status_t stat;
      snapshot_t   snap;
      logic        dev_rd;
      logic [4:0]  dev_addr;
      logic        chk_byte;
      logic [7:0]  exp_byte;
      logic [3:0]  exp_lat;
      logic [31:0] exp_rd;
      ctrl_t       exp_ctrl;
      logic [31:0] exp_set;
      logic [31:0] exp_clr;
      logic        exp_irq;
      logic [7:0]  exp_ocr;
      logic [31:0] exp_size;
   } step_t;

   logic clk;
   logic resetn;
   reg_req_t req;
   dev_events_t evt;
   dev_status_t stat;
   snapshot_t snap;
   logic [4:0] dev_addr;
   logic dev_rd;
   logic [7:0] dev_byte;
   ctrl_t ctrl;
   logic [31:0] csr_set;
   logic [31:0] csr_clr;
   logic [7:0] ocr_high;
   logic [31:0] size;
   logic irq;
   logic rd_valid;
   logic [31:0] rd_data;
   logic start;
   step_t cur;
   int done_count;
   int fail_count;

   step_t table_q[$];
   step_t r;
   logic [31:0] lat_m;
   logic [31:0] intr_en_m;
   logic [7:0] ocr_m;
   logic [31:0] size_m;
   dev_status_t cur_stat;
   snapshot_t cur_snap;
   logic [31:0] mem_m[8];
   logic [31:0] snap_w[8];
   integer seed;

   sd_reg_block dut_i (
      .clk(clk), .resetn(resetn), .req_i(req), .dev_evt_i(evt), .dev_stat_i(stat),
      .dev_snap_i(snap), .dev_ram_addr_i(dev_addr), .dev_ram_rd_i(dev_rd),
      .dev_ram_data_o(dev_byte), .ctrl_o(ctrl), .csr_set_o(csr_set), .csr_clr_o(csr_clr),
      .ocr_high_o(ocr_high), .size_o(size), .irq_o(irq), .rd_valid_o(rd_valid),
      .rd_data_o(rd_data)
   );

   sd_reg_checker checker_i (
      .clk(clk), .resetn(resetn), .start_i(start), .exp_lat_i(cur.exp_lat),
      .exp_rd_i(cur.exp_rd), .exp_ctrl_i(cur.exp_ctrl), .exp_set_i(cur.exp_set),
      .exp_clr_i(cur.exp_clr), .exp_irq_i(cur.exp_irq), .chk_byte_i(cur.chk_byte),
      .exp_byte_i(cur.exp_byte), .exp_ocr_i(cur.exp_ocr), .exp_size_i(cur.exp_size),
      .rd_valid_i(rd_valid), .rd_data_i(rd_data),
      .ctrl_i(ctrl), .csr_set_i(csr_set), .csr_clr_i(csr_clr), .irq_i(irq),
      .dev_byte_i(dev_byte), .ocr_high_i(ocr_high), .size_i(size),
      .done_count_o(done_count), .fail_count_o(fail_count)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Level fields at their positions in the status word
   function automatic logic [31:0] level_bits(dev_status_t s);
      logic [31:0] w;
      w        = '0;
      w[28:26] = s.dat_error_code;
      w[24]    = s.pre_erase_used;
      w[23]    = s.block_limit_used;
      w[22]    = s.got_cmd8;
      w[20]    = s.is_inactive;
      w[15]    = s.last_cmd_valid;
      w[14]    = s.last_cmd_ignored;
      w[13]    = s.last_cmd_is_acmd;
      w[12:7]  = s.last_cmd_index;
      w[6]     = s.saved_cmd_is_acmd;
      w[5:0]   = s.saved_cmd_index;
      return w;
   endfunction

   function automatic logic [31:0] event_bits(dev_events_t e, logic [31:0] lat);
      logic [31:0] w;
      w     = '0;
      w[16] = e.new_cmd_saved;
      w[17] = e.new_cmd_saved & lat[16];
      w[18] = e.new_cmd;
      w[19] = e.new_cmd & lat[18];
      w[21] = e.got_reset_cmd;
      w[25] = e.dat_done;
      return w;
   endfunction

   task automatic new_row();
      r      = '0;
      r.stat = cur_stat;
      r.snap = cur_snap;
   endtask

   // Status, irq, pulse and register expectations follow the latch model
   task automatic add_row();
      logic [31:0] now;
      now = lat_m | event_bits(r.evt, lat_m);
      r.exp_irq = |((now | level_bits(r.stat)) & intr_en_m);
      if (r.req.re && r.req.addr == ADDR_STATUS) begin
         r.exp_lat = 4'd1;
         r.exp_rd  = now | level_bits(r.stat);
         lat_m     = '0;
      end else
         lat_m = now;
      if (r.req.we && r.req.addr == ADDR_CONTROL)
         r.exp_ctrl = lat_m[16] ? 3'b000 : r.req.wdata[2:0];
      if (r.req.we && r.req.addr == ADDR_CSR_SET)
         r.exp_set = r.req.wdata;
      if (r.req.we && r.req.addr == ADDR_CSR_CLR)
         r.exp_clr = r.req.wdata;
      if (r.req.we && r.req.addr == ADDR_INTR_EN)
         intr_en_m = r.req.wdata & `SD_INTR_EN_MASK;
      // A card reset wins over a register write
      if (r.evt.got_reset_cmd) begin
         ocr_m  = '0;
         size_m = '0;
      end else if (r.req.we && r.req.addr == ADDR_OCR)
         ocr_m = r.req.wdata[31:24];
      else if (r.req.we && r.req.addr == ADDR_SIZE)
         size_m = r.req.wdata;
      r.exp_ocr  = ocr_m;
      r.exp_size = size_m;
      table_q.push_back(r);
   endtask

   task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
      new_row();
      r.req.we    = 1'b1;
      r.req.addr  = a;
      r.req.wdata = d;
      add_row();
   endtask

   task automatic read_reg(input logic [4:0] a, input logic [31:0] exp, input logic [3:0] lat);
      new_row();
      r.req.re  = 1'b1;
      r.req.addr = a;
      r.exp_rd  = exp;
      r.exp_lat = lat;
      add_row();
   endtask

   task automatic send_event(input dev_events_t e);
      new_row();
      r.evt = e;
      add_row();
   endtask

   task automatic byte_read(input logic [4:0] a, input logic [7:0] exp);
      new_row();
      r.dev_rd   = 1'b1;
      r.dev_addr = a;
      r.chk_byte = 1'b1;
      r.exp_byte = exp;
      add_row();
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      int i;
      // Memory round trip with byte 0 as the top byte of each word
      for (i = 0; i < 8; i++) begin
         mem_m[i] = $random(seed);
         write_reg(5'(i), mem_m[i]);
      end
      for (i = 0; i < 8; i++)
         read_reg(5'(i), mem_m[i], 4'd5);
      for (i = 0; i < 32; i++)
         byte_read(5'(i), 8'(mem_m[i / 4] >> (8 * (3 - i % 4))));
      // Masked registers and zero reads
      write_reg(ADDR_OCR, 32'hffff_ffff);
      read_reg(ADDR_OCR, 32'hff00_0000, 4'd1);
      write_reg(ADDR_INTR_EN, 32'hffff_ffff);
      read_reg(ADDR_INTR_EN, `SD_INTR_EN_MASK, 4'd1);
      rnd = $random(seed);
      write_reg(ADDR_SIZE, rnd);
      read_reg(ADDR_SIZE, rnd, 4'd1);
      read_reg(ADDR_CONTROL, '0, 4'd1);
      read_reg(ADDR_CSR_SET, '0, 4'd1);
      read_reg(ADDR_CSR_CLR, '0, 4'd1);
      read_reg(5'd23, '0, 4'd1);
      read_reg(5'd31, '0, 4'd1);
      // Status latching with a missed new_cmd
      send_event('{new_cmd: 1'b1, default: 1'b0});
      send_event('{new_cmd: 1'b1, default: 1'b0});
      send_event('{dat_done: 1'b1, default: 1'b0});
      rnd = $random(seed);
      cur_stat = rnd[22:0];
      read_reg(ADDR_STATUS, '0, 4'd1);
      read_reg(ADDR_STATUS, '0, 4'd1);
      cur_stat = '0;
      // Snapshot taken at a status read before the inputs move on
      for (i = 0; i < 8; i++)
         snap_w[i] = $random(seed);
      cur_snap = {snap_w[0], snap_w[1], snap_w[2], snap_w[3],
                  snap_w[4], snap_w[5], snap_w[6], snap_w[7]};
      read_reg(ADDR_STATUS, '0, 4'd1);
      cur_snap = {$random(seed), $random(seed), $random(seed), $random(seed),
                  $random(seed), $random(seed), $random(seed), $random(seed)};
      for (i = 0; i < 8; i++)
         read_reg(5'(9 + i), (i == 6) ? (snap_w[i] & 32'h007f_ffff) : snap_w[i], 4'd1);
      // Control gating and card-status pulses
      send_event('{new_cmd_saved: 1'b1, default: 1'b0});
      write_reg(ADDR_CONTROL, 32'h7);
      read_reg(ADDR_STATUS, '0, 4'd1);
      write_reg(ADDR_CONTROL, 32'h5);
      write_reg(ADDR_CSR_SET, $random(seed));
      write_reg(ADDR_CSR_CLR, $random(seed));
      // Interrupt from a latched new_cmd only
      write_reg(ADDR_INTR_EN, 32'h0004_0000);
      send_event('{new_cmd: 1'b1, default: 1'b0});
      new_row();
      add_row();
      read_reg(ADDR_STATUS, '0, 4'd1);
      new_row();
      add_row();
      // Card reset clears OCR and size only
      write_reg(ADDR_OCR, 32'hffff_ffff);
      write_reg(ADDR_SIZE, $random(seed));
      send_event('{got_reset_cmd: 1'b1, default: 1'b0});
      read_reg(ADDR_OCR, '0, 4'd1);
      read_reg(ADDR_SIZE, '0, 4'd1);
      read_reg(ADDR_INTR_EN, 32'h0004_0000, 4'd1);
   endtask

   initial begin
      int i;
      int prev;
      int waited;
      logic timed_out;
      resetn    = 1'b0;
      req       = '0;
      evt       = '0;
      stat      = '0;
      snap      = '0;
      dev_addr  = '0;
      dev_rd    = 1'b0;
      start     = 1'b0;
      cur       = '0;
      timed_out = 1'b0;
      seed      = 32'hd885_588b;
      lat_m     = '0;
      intr_en_m = '0;
      ocr_m     = '0;
      size_m    = '0;
      cur_stat  = '0;
      cur_snap  = '0;
      build_table();
      for (i = 0; i < 5; i++)
         @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;
      for (i = 0; i < table_q.size(); i++) begin
         @(negedge clk);
         cur      = table_q[i];
         req      = cur.req;
         evt      = cur.evt;
         stat     = cur.stat;
         snap     = cur.snap;
         dev_addr = cur.dev_addr;
         dev_rd   = cur.dev_rd;
         prev     = done_count;
         start    = 1'b1;
         @(negedge clk);
         req    = '0;
         evt    = '0;
         dev_rd = 1'b0;
         start  = 1'b0;
         waited = 0;
         while (done_count == prev && waited < 20) begin
            @(negedge clk);
            waited++;
         end
         if (done_count == prev) begin
            $display("timeout: checker did not finish step %0d", i);
            timed_out = 1'b1;
            break;
         end
      end
      $display("tests run %0d, failed %0d", done_count, fail_count);
      if (timed_out || fail_count != 0)
         $display("STATUS: FAIL");
      else
         $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/sd_regs_pkg.sv
design/cid_csd_ram.sv
design/status_latch.sv
design/snapshot_regs.sv
design/config_regs.sv
design/sd_reg_block.sv
test/sd_reg_checker.sv
test/tb_sd_reg_block.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sd_reg_block -f list.f \
   --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
   exit 0
else
   exit 1
fi
